/* all.f */
verilog/axi_rd_pkg.sv
verilog/beat_pkg.sv
verilog/axi_burst_reader.sv
verilog/beat_fifo.sv
verilog/burst_summarizer.sv
verilog/burst_fetch_top.sv
dv/tb_burst_fetch.sv

/* dv/tb_burst_fetch.sv */
`default_nettype none

module tb_burst_fetch
  import axi_rd_pkg::*;
  import beat_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 4;
  localparam int EXP_BURSTS  = 80;
  localparam int WATCHDOG_NS = (EXP_BURSTS * 200 + 2000) * CLK_PERIOD;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  i_start;
  logic                  i_hold;
  logic                  i_arready;
  logic                  i_rvalid;
  logic [AXI_DATA_W-1:0] i_rdata;
  logic                  i_rlast;
  logic [1:0]            i_rresp;
  logic                  o_arvalid;
  logic [AXI_ADDR_W-1:0] o_araddr;
  logic [7:0]            o_arlen;
  logic [2:0]            o_arsize;
  logic [1:0]            o_arburst;
  logic [AXI_ID_W-1:0]   o_arid;
  logic [3:0]            o_arcache;
  logic [2:0]            o_arprot;
  logic                  o_arlock;
  logic                  o_rready;
  logic                  o_busy;
  logic [SUM_W-1:0]      o_sum;
  logic [PAR_W-1:0]      o_parity;
  logic [AXI_ADDR_W-1:0] o_sum_addr;
  logic                  o_sum_err;
  logic                  o_sum_valid;

  // scoreboard state
  logic [AXI_ADDR_W-1:0] exp_addr_q [$];
  logic                  exp_err_q [$];
  logic [AXI_ADDR_W-1:0] exp_ar_addr = '0;
  logic [AXI_ADDR_W-1:0] err_addr = 32'hffff_ffff;
  logic [31:0]           rng_state = 32'd52;
  int                    ar_count = 0;
  int                    sum_count = 0;
  int                    mismatch_errs = 0;
  int                    other_errs = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  burst_fetch_top burst_fetch_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_hold      (i_hold),
    .i_arready   (i_arready),
    .o_arvalid   (o_arvalid),
    .o_araddr    (o_araddr),
    .o_arlen     (o_arlen),
    .o_arsize    (o_arsize),
    .o_arburst   (o_arburst),
    .o_arid      (o_arid),
    .o_arcache   (o_arcache),
    .o_arprot    (o_arprot),
    .o_arlock    (o_arlock),
    .i_rvalid    (i_rvalid),
    .i_rdata     (i_rdata),
    .i_rlast     (i_rlast),
    .i_rresp     (i_rresp),
    .o_rready    (o_rready),
    .o_busy      (o_busy),
    .o_sum       (o_sum),
    .o_parity    (o_parity),
    .o_sum_addr  (o_sum_addr),
    .o_sum_err   (o_sum_err),
    .o_sum_valid (o_sum_valid)
  );

  // ******************************
  // data generator
  // ******************************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // lane k of beat j with the generator reseeded by the burst address
  function automatic logic [31:0] lane_word(input logic [31:0] addr, input int j, input int k);
    logic [31:0] s;
    s = 32'd52 ^ addr;
    for (int n = 0; n <= 4 * j + k; n++) begin
      s = xorshift32(s);
    end
    return (addr + 32'(16 * j + k)) ^ s;
  endfunction

  task automatic expected_summary(input logic [AXI_ADDR_W-1:0] addr,
                                  output logic [SUM_W-1:0] sum, output logic [PAR_W-1:0] par);
    logic [31:0] w;
    logic [31:0] x;
    sum = '0;
    x   = '0;
    for (int j = 0; j < 8; j++) begin
      for (int k = 0; k < 4; k++) begin
        w   = lane_word(addr, j, k);
        sum = sum + w;
        x   = x ^ w;
      end
    end
    // xor of all bytes folds down to the xor of the lane xor
    par = x[7:0] ^ x[15:8] ^ x[23:16] ^ x[31:24];
  endtask

  // ******************************
  // compare tasks
  // ******************************
  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_ar(input logic [AXI_ADDR_W-1:0] exp_addr);
    if (o_araddr !== exp_addr || o_arlen !== 8'd7 || o_arsize !== 3'd4 ||
        o_arburst !== 2'd1 || o_arid !== 4'd1 || o_arcache !== 4'd0 ||
        o_arprot !== 3'd0 || o_arlock !== 1'b0) begin
      mismatch_errs++;
      $display("mismatch at %0t: AR addr %0d len %0d size %0d burst %0d id %0d, expected addr %0d",
               $time, o_araddr, o_arlen, o_arsize, o_arburst, o_arid, exp_addr);
    end
  endtask

  task automatic compare_summary(input logic [SUM_W-1:0] exp_sum, input logic [PAR_W-1:0] exp_par,
                                 input logic [AXI_ADDR_W-1:0] exp_addr, input logic exp_err);
    if (o_sum !== exp_sum || o_parity !== exp_par || o_sum_addr !== exp_addr ||
        o_sum_err !== exp_err) begin
      mismatch_errs++;
      $display("mismatch at %0t: summary %h/%h/%0d/%b, expected %h/%h/%0d/%b", $time,
               o_sum, o_parity, o_sum_addr, o_sum_err, exp_sum, exp_par, exp_addr, exp_err);
    end
  endtask

  // ******************************
  // axi slave model
  // ******************************
  initial begin : axi_slave
    logic [AXI_ADDR_W-1:0] addr;
    beat_t                 beat;
    int                    j;
    logic                  took;
    @(posedge rst_n);
    forever begin
      i_arready = 1'b0;
      while (!i_arready) begin
        @(negedge clk);
        rng_state = xorshift32(rng_state);
        i_arready = o_arvalid & rng_state[0];
      end
      addr = o_araddr;
      compare_ar(exp_ar_addr);
      exp_addr_q.push_back(exp_ar_addr);
      exp_err_q.push_back(exp_ar_addr == err_addr);
      exp_ar_addr = (exp_ar_addr == 32'd8064) ? '0 : exp_ar_addr + 32'd128;
      ar_count++;
      // a valid beat is held until rready takes it
      j    = 0;
      took = 1'b0;
      while (j < 8) begin
        @(negedge clk);
        i_arready = 1'b0;
        if (i_rvalid && took) begin
          j++;
        end
        rng_state = xorshift32(rng_state);
        if (j < 8) begin
          if (!i_rvalid || took) begin
            i_rvalid = (rng_state[1:0] != 2'b00);
          end
          for (int k = 0; k < 4; k++) begin
            beat.dw[k] = lane_word(addr, j, k);
          end
          i_rdata = beat;
          i_rlast = (j == 7);
          i_rresp = (addr == err_addr && j == 3) ? 2'b10 : 2'b00;
        end else begin
          i_rvalid = 1'b0;
        end
        took = o_rready;
      end
    end
  end

  // summaries checked in issue order
  always @(negedge clk) begin : summary_monitor
    logic [AXI_ADDR_W-1:0] a;
    logic                  e;
    logic [SUM_W-1:0]      s;
    logic [PAR_W-1:0]      p;
    if (rst_n === 1'b1 && o_sum_valid === 1'b1) begin
      if (exp_addr_q.size() == 0) begin
        other_errs++;
        $display("summary at %0t with no burst outstanding", $time);
      end else begin
        a = exp_addr_q.pop_front();
        e = exp_err_q.pop_front();
        expected_summary(a, s, p);
        compare_summary(s, p, a, e);
        sum_count++;
      end
    end
  end

  // ******************************
  // wait helpers
  // ******************************
  task automatic wait_ar_count(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (ar_count < target && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (ar_count < target) begin
      other_errs++;
      $display("timed out at %0t waiting for AR number %0d", $time, target);
    end
  endtask

  task automatic wait_summaries(input int target);
    int cycles;
    cycles = 0;
    while (sum_count < target && cycles < 200 * (target - sum_count) + 100) begin
      @(negedge clk);
      cycles++;
    end
    if (sum_count < target) begin
      other_errs++;
      $display("timed out at %0t waiting for summary number %0d", $time, target);
    end
  endtask

  // ******************************
  // tests
  // ******************************
  task automatic check_reset();
    repeat (5) @(negedge clk);
    compare_flag("o_arvalid", o_arvalid, 1'b0);
    compare_flag("o_rready", o_rready, 1'b0);
    compare_flag("o_sum_valid", o_sum_valid, 1'b0);
    compare_flag("o_busy", o_busy, 1'b0);
    rst_n = 1'b1;
    @(negedge clk);
    compare_flag("o_rready", o_rready, 1'b1);
  endtask

  task automatic single_burst();
    int base;
    base = ar_count;
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    wait_summaries(base + 1);
    repeat (30) @(negedge clk);
    if (ar_count != base + 1 || sum_count != base + 1) begin
      other_errs++;
      $display("single start gave %0d bursts and %0d summaries", ar_count - base,
               sum_count - base);
    end
  endtask

  // 66 bursts crosses the wrap after 8064
  task automatic stream_wrap();
    i_start = 1'b1;
    wait_ar_count(ar_count + 66, 200 * 66);
    i_start = 1'b0;
    wait_summaries(ar_count);
  endtask

  task automatic hold_backpressure();
    logic dropped;
    dropped = 1'b0;
    i_start = 1'b1;
    repeat (8) @(negedge clk);
    i_hold = 1'b1;
    repeat (40) begin
      @(negedge clk);
      dropped = dropped | ~o_rready;
    end
    i_hold = 1'b0;
    if (!dropped) begin
      other_errs++;
      $display("o_rready never dropped while the summarizer was held");
    end
    wait_ar_count(ar_count + 2, 400);
    i_start = 1'b0;
    wait_summaries(ar_count);
  endtask

  // one errored burst followed by a clean burst
  task automatic slave_error();
    err_addr = exp_ar_addr;
    i_start  = 1'b1;
    wait_ar_count(ar_count + 2, 400);
    i_start = 1'b0;
    wait_summaries(ar_count);
    err_addr = 32'hffff_ffff;
  endtask

  task automatic stop_mid_burst();
    int base;
    base = ar_count;
    i_start = 1'b1;
    wait_ar_count(base + 1, 200);
    repeat (3) @(negedge clk);
    i_start = 1'b0;
    wait_summaries(base + 1);
    repeat (50) begin
      @(negedge clk);
      compare_flag("o_arvalid", o_arvalid, 1'b0);
      compare_flag("o_busy", o_busy, 1'b0);
    end
    if (ar_count != base + 1) begin
      other_errs++;
      $display("AR issued after start was dropped");
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, run did not finish", $time);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    i_start   = 1'b0;
    i_hold    = 1'b0;
    i_arready = 1'b0;
    i_rvalid  = 1'b0;
    i_rdata   = '0;
    i_rlast   = 1'b0;
    i_rresp   = 2'b00;
    check_reset();
    single_burst();
    stream_wrap();
    hold_backpressure();
    slave_error();
    stop_mid_burst();
    $display("%0d summaries checked, %0d mismatches, %0d other errors", sum_count,
             mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/burst_fetch_top.sv */
`default_nettype none

module burst_fetch_top
  import axi_rd_pkg::*;
  import beat_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   i_start,
  input  wire                   i_hold,
  // axi read port
  input  wire                   i_arready,
  output logic                  o_arvalid,
  output logic [AXI_ADDR_W-1:0] o_araddr,
  output logic [7:0]            o_arlen,
  output logic [2:0]            o_arsize,
  output logic [1:0]            o_arburst,
  output logic [AXI_ID_W-1:0]   o_arid,
  output logic [3:0]            o_arcache,
  output logic [2:0]            o_arprot,
  output logic                  o_arlock,
  input  wire                   i_rvalid,
  input  wire  [AXI_DATA_W-1:0] i_rdata,
  input  wire                   i_rlast,
  input  wire  [1:0]            i_rresp,
  output logic                  o_rready,
  output logic                  o_busy,
  // burst summary
  output logic [SUM_W-1:0]      o_sum,
  output logic [PAR_W-1:0]      o_parity,
  output logic [AXI_ADDR_W-1:0] o_sum_addr,
  output logic                  o_sum_err,
  output logic                  o_sum_valid
);

  // reader to fifo
  logic  push;
  beat_t push_beat;
  logic  push_last;
  logic  push_err;
  logic  fifo_full;

  // fifo to summarizer
  logic  pop;
  beat_t head_beat;
  logic  head_last;
  logic  head_err;
  logic  fifo_empty;

  axi_burst_reader axi_burst_reader_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_arready   (i_arready),
    .o_arvalid   (o_arvalid),
    .o_araddr    (o_araddr),
    .o_arlen     (o_arlen),
    .o_arsize    (o_arsize),
    .o_arburst   (o_arburst),
    .o_arid      (o_arid),
    .o_arcache   (o_arcache),
    .o_arprot    (o_arprot),
    .o_arlock    (o_arlock),
    .i_rvalid    (i_rvalid),
    .i_rdata     (i_rdata),
    .i_rlast     (i_rlast),
    .i_rresp     (i_rresp),
    .o_rready    (o_rready),
    .i_fifo_full (fifo_full),
    .o_push      (push),
    .o_push_beat (push_beat),
    .o_push_last (push_last),
    .o_push_err  (push_err),
    .o_busy      (o_busy)
  );

  beat_fifo beat_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_push      (push),
    .i_push_beat (push_beat),
    .i_push_last (push_last),
    .i_push_err  (push_err),
    .i_pop       (pop),
    .o_head_beat (head_beat),
    .o_head_last (head_last),
    .o_head_err  (head_err),
    .o_empty     (fifo_empty),
    .o_full      (fifo_full)
  );

  burst_summarizer burst_summarizer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_hold      (i_hold),
    .i_empty     (fifo_empty),
    .i_head_beat (head_beat),
    .i_head_last (head_last),
    .i_head_err  (head_err),
    .o_pop       (pop),
    .o_sum       (o_sum),
    .o_parity    (o_parity),
    .o_sum_addr  (o_sum_addr),
    .o_sum_err   (o_sum_err),
    .o_sum_valid (o_sum_valid)
  );

endmodule

`default_nettype wire

/* verilog/burst_summarizer.sv */
`default_nettype none

module burst_summarizer
  import axi_rd_pkg::*;
  import beat_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   i_hold,
  input  wire                   i_empty,
  input  wire beat_t            i_head_beat,
  input  wire                   i_head_last,
  input  wire                   i_head_err,
  output logic                  o_pop,
  output logic [SUM_W-1:0]      o_sum,
  output logic [PAR_W-1:0]      o_parity,
  output logic [AXI_ADDR_W-1:0] o_sum_addr,
  output logic                  o_sum_err,
  output logic                  o_sum_valid
);

  logic [SUM_W-1:0]      beat_sum;
  logic [PAR_W-1:0]      beat_par;
  logic [SUM_W-1:0]      sum_acc;
  logic [PAR_W-1:0]      par_acc;
  logic                  err_acc;
  logic [AXI_ADDR_W-1:0] addr_q;
  logic                  pop_last;

  assign o_pop    = ~i_empty & ~i_hold;
  assign pop_last = o_pop & i_head_last;

  // per-beat reduction of the head
  always_comb begin
    beat_sum = '0;
    beat_par = '0;
    for (int i = 0; i < BEAT_DW; i++) begin
      beat_sum = beat_sum + i_head_beat.dw[i];
    end
    for (int j = 0; j < BEAT_BYTES; j++) begin
      beat_par = beat_par ^ i_head_beat.b[j];
    end
  end

  // ******************************
  // accumulators
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_acc     <= '0;
      par_acc     <= '0;
      err_acc     <= 1'b0;
      addr_q      <= '0;
      o_sum_valid <= 1'b0;
    end else begin
      o_sum_valid <= pop_last;
      if (pop_last) begin
        sum_acc <= '0;
        par_acc <= '0;
        err_acc <= 1'b0;
        // same walk as the reader, so no address rides in the fifo
        if (addr_q == AXI_ADDR_LAST) begin
          addr_q <= '0;
        end else begin
          addr_q <= addr_q + AXI_ADDR_STEP;
        end
      end else if (o_pop) begin
        sum_acc <= sum_acc + beat_sum;
        par_acc <= par_acc ^ beat_par;
        err_acc <= err_acc | i_head_err;
      end
    end
  end

  // burst result, includes the last beat
  always_ff @(posedge clk) begin
    if (pop_last) begin
      o_sum      <= sum_acc + beat_sum;
      o_parity   <= par_acc ^ beat_par;
      o_sum_err  <= err_acc | i_head_err;
      o_sum_addr <= addr_q;
    end
  end

endmodule

`default_nettype wire

/* verilog/beat_fifo.sv */
`default_nettype none

module beat_fifo
  import beat_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  input  wire          i_push,
  input  wire beat_t   i_push_beat,
  input  wire          i_push_last,
  input  wire          i_push_err,
  input  wire          i_pop,
  output beat_t        o_head_beat,
  output logic         o_head_last,
  output logic         o_head_err,
  output logic         o_empty,
  output logic         o_full
);

  beat_t                 mem_beat [FIFO_DEPTH];
  logic                  mem_last [FIFO_DEPTH];
  logic                  mem_err  [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic [FIFO_PTR_W:0]   count_nxt;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = i_push & ~o_full;
  assign do_pop  = i_pop & ~o_empty;

  always_comb begin
    count_nxt = count;
    if (do_push && !do_pop) begin
      count_nxt = count + 1'b1;
    end else if (do_pop && !do_push) begin
      count_nxt = count - 1'b1;
    end
  end

  // ******************************
  // pointers and flags
  // ******************************
  // full comes up high in reset so no beat is taken before the first clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_full  <= 1'b1;
      o_empty <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count   <= count_nxt;
      o_full  <= (count_nxt == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
      o_empty <= (count_nxt == '0);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_beat[wr_ptr] <= i_push_beat;
      mem_last[wr_ptr] <= i_push_last;
      mem_err[wr_ptr]  <= i_push_err;
    end
  end

  // fall-through head
  assign o_head_beat = mem_beat[rd_ptr];
  assign o_head_last = mem_last[rd_ptr];
  assign o_head_err  = mem_err[rd_ptr];

endmodule

`default_nettype wire

/* verilog/axi_burst_reader.sv */
`default_nettype none

module axi_burst_reader
  import axi_rd_pkg::*;
  import beat_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   i_start,
  // ar channel
  input  wire                   i_arready,
  output logic                  o_arvalid,
  output logic [AXI_ADDR_W-1:0] o_araddr,
  output logic [7:0]            o_arlen,
  output logic [2:0]            o_arsize,
  output logic [1:0]            o_arburst,
  output logic [AXI_ID_W-1:0]   o_arid,
  output logic [3:0]            o_arcache,
  output logic [2:0]            o_arprot,
  output logic                  o_arlock,
  // r channel
  input  wire                   i_rvalid,
  input  wire  [AXI_DATA_W-1:0] i_rdata,
  input  wire                   i_rlast,
  input  wire  [1:0]            i_rresp,
  output logic                  o_rready,
  // beat fifo side
  input  wire                   i_fifo_full,
  output logic                  o_push,
  output beat_t                 o_push_beat,
  output logic                  o_push_last,
  output logic                  o_push_err,
  output logic                  o_busy
);

  // controller: idle when both flags low, address phase on o_arvalid,
  // data phase on data_phase
  logic data_phase;
  logic beat_acc;
  logic burst_done;

  // fixed burst shape
  assign o_arlen   = AXI_BURST_LEN;
  assign o_arsize  = AXI_SIZE_CODE;
  assign o_arburst = AXI_BURST_INCR;
  assign o_arid    = AXI_RD_ID;
  assign o_arcache = 4'd0;
  assign o_arprot  = 3'd0;
  assign o_arlock  = 1'b0;

  // take beats only while the fifo has room
  assign o_rready   = ~i_fifo_full;
  assign beat_acc   = i_rvalid & o_rready;
  assign burst_done = data_phase & beat_acc & i_rlast;

  // ******************************
  // ar / r sequencing
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_arvalid  <= 1'b0;
      data_phase <= 1'b0;
    end else if (o_arvalid) begin
      // hold address until the slave takes it
      if (i_arready) begin
        o_arvalid  <= 1'b0;
        data_phase <= 1'b1;
      end
    end else if (data_phase) begin
      if (burst_done) begin
        data_phase <= 1'b0;
      end
    end else if (i_start) begin
      o_arvalid <= 1'b1;
    end
  end

  // next burst address, wraps after the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_araddr <= '0;
    end else if (burst_done) begin
      if (o_araddr == AXI_ADDR_LAST) begin
        o_araddr <= '0;
      end else begin
        o_araddr <= o_araddr + AXI_ADDR_STEP;
      end
    end
  end

  // beat forwarding
  assign o_push      = beat_acc;
  assign o_push_beat = i_rdata;
  assign o_push_last = i_rlast;
  assign o_push_err  = (i_rresp != AXI_RESP_OKAY);

  assign o_busy = o_arvalid | data_phase;

endmodule

`default_nettype wire

/* verilog/beat_pkg.sv */
`default_nettype none

// ******************************
// beat format and buffer sizing
// ******************************
package beat_pkg;

  // summary widths, also the lane widths of a beat
  localparam int SUM_W = 32;
  localparam int PAR_W = 8;

  // lanes per 128-bit beat
  localparam int BEAT_DW    = 4;
  localparam int BEAT_BYTES = 16;

  // one beat, read as dwords for the sum and as bytes for parity
  typedef union packed {
    logic [BEAT_DW-1:0][SUM_W-1:0]    dw;
    logic [BEAT_BYTES-1:0][PAR_W-1:0] b;
  } beat_t;

  // beat buffer
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = 4;

endpackage

`default_nettype wire

/* verilog/axi_rd_pkg.sv */
`default_nettype none

// ******************************
// axi4 read channel constants
// ******************************
package axi_rd_pkg;

  // bus widths
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 128;
  localparam int AXI_ID_W   = 4;

  // fixed id, no reordering needed
  localparam logic [AXI_ID_W-1:0] AXI_RD_ID = 4'd1;

  // burst shape: 8 beats of 16 bytes, incrementing
  localparam logic [7:0] AXI_BURST_LEN  = 8'd7;
  localparam logic [2:0] AXI_SIZE_CODE  = 3'd4;
  localparam logic [1:0] AXI_BURST_INCR = 2'd1;

  // address walk, 64 bursts then back to 0
  localparam logic [AXI_ADDR_W-1:0] AXI_ADDR_STEP = 32'd128;
  localparam logic [AXI_ADDR_W-1:0] AXI_ADDR_LAST = 32'd8064;

  localparam logic [1:0] AXI_RESP_OKAY = 2'd0;

endpackage

`default_nettype wire
